// File: rtl/prog_pkg.sv
`default_nettype none

package prog_pkg;

    // Host opcodes understood by the programmer
    typedef enum logic [7:0] {
        OP_PING      = 8'hCC,
        OP_READ_ID   = 8'hF0,
        OP_READ_SREG = 8'hF1,
        OP_ERASE     = 8'hF4
    } prog_op_t;

    localparam logic [7:0] REPLY_HEAD = 8'hFE;  // First byte of every reply

    typedef struct packed {
        logic       valid;   // One-cycle strobe
        logic [7:0] opcode;  // Raw opcode byte, may be unknown
    } cmd_t;

    typedef struct packed {
        logic            start;   // One-cycle strobe
        logic [7:0]      opcode;
        logic [1:0]      len;     // Number of data bytes, 1 to 3
        logic [2:0][7:0] data;    // data[0] goes out first
    } reply_t;

endpackage

`default_nettype wire

// File: rtl/flash_pkg.sv
`default_nettype none

package flash_pkg;

    // SPI NOR command bytes
    typedef enum logic [7:0] {
        FL_READ_ID    = 8'h9F,
        FL_READ_SR1   = 8'h05,
        FL_READ_SR2   = 8'h35,
        FL_WRITE_EN   = 8'h06,
        FL_CHIP_ERASE = 8'hC7,
        FL_DUMMY      = 8'h00
    } flash_cmd_t;

    // Status register 1 bits
    localparam int SR_BSY = 0;
    localparam int SR_WEL = 1;

    typedef struct packed {
        logic       start;  // One-cycle strobe
        logic [7:0] data;   // Byte shifted out on mosi
    } spi_req_t;

endpackage

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
)
(
    input  wire        clk,
    input  wire        rst,
    input  wire        rx,
    output logic       rx_valid,
    output logic [7:0] rx_data
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CW-1:0] HALF = CW'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CW-1:0] FULL = CW'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t     state;
    logic [1:0]    sync;     // Two-flop synchronizer
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    shreg;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            sync     <= 2'b11;
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            sync     <= {sync[0], rx};
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE:
                begin
                    clk_cnt <= '0;
                    if (!sync[1])
                        state <= RX_START;  // Falling edge of start bit
                end
                RX_START:
                begin
                    if (clk_cnt == HALF)
                    begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= sync[1] ? RX_IDLE : RX_DATA;  // Reject glitch
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                RX_DATA:
                begin
                    if (clk_cnt == FULL)
                    begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                RX_STOP:
                begin
                    if (clk_cnt == FULL)
                    begin
                        rx_valid <= sync[1];  // Framing error drops the byte
                        state    <= RX_IDLE;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk)
    begin
        if (state == RX_DATA && clk_cnt == FULL)
            shreg <= {sync[1], shreg[7:1]};
    end

    assign rx_data = shreg;

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
)
(
    input  wire        clk,
    input  wire        rst,
    input  wire        tx_start,
    input  wire  [7:0] tx_data,
    output logic       tx,
    output logic       tx_busy
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CW-1:0] FULL = CW'(CLKS_PER_BIT - 1);

    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_cnt;  // 0 is the start bit, 9 the stop bit
    logic [8:0]    shreg;    // Data bits with stop bit on top

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end
        else if (!tx_busy)
        begin
            if (tx_start)
            begin
                tx      <= 1'b0;  // Start bit
                tx_busy <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end
        else if (clk_cnt == FULL)
        begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9)
                tx_busy <= 1'b0;  // Stop bit done
            else
            begin
                tx      <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
        else
            clk_cnt <= clk_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!tx_busy && tx_start)
            shreg <= {1'b1, tx_data};
        else if (tx_busy && clk_cnt == FULL)
            shreg <= {1'b1, shreg[8:1]};
    end

endmodule

`default_nettype wire

// File: rtl/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master import flash_pkg::*; #(
    parameter int SPI_HALF_CLKS = 2
)
(
    input  wire           clk,
    input  wire           rst,
    input  wire spi_req_t req,
    input  wire           miso,
    output logic          mosi,
    output logic          sck,
    output logic          busy,
    output logic [7:0]    rdata
);

    localparam int HW = $clog2(SPI_HALF_CLKS + 1);
    localparam logic [HW-1:0] HALF = HW'(SPI_HALF_CLKS - 1);

    logic [HW-1:0] half_cnt;
    logic [3:0]    edge_cnt;  // Even is rising, odd is falling
    logic [7:0]    shreg;
    logic          edge_now;

    assign edge_now = busy && (half_cnt == HALF);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            mosi     <= 1'b0;
            sck      <= 1'b0;
            busy     <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= '0;
        end
        else if (!busy)
        begin
            if (req.start)
            begin
                busy     <= 1'b1;
                mosi     <= req.data[7];  // MSB ready before first rise
                half_cnt <= '0;
                edge_cnt <= '0;
            end
        end
        else if (edge_now)
        begin
            half_cnt <= '0;
            edge_cnt <= edge_cnt + 1'b1;
            sck      <= ~edge_cnt[0];
            if (edge_cnt == 4'd15)
                busy <= 1'b0;
            else if (edge_cnt[0])
                mosi <= shreg[7];  // Next bit on falling edge
        end
        else
            half_cnt <= half_cnt + 1'b1;
    end

    // Sample miso on rising edge
    always_ff @(posedge clk)
    begin
        if (!busy && req.start)
            shreg <= req.data;
        else if (edge_now && !edge_cnt[0])
            shreg <= {shreg[6:0], miso};
    end

    assign rdata = shreg;

endmodule

`default_nettype wire

// File: rtl/packet_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module packet_receiver import prog_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        rx_valid,
    input  wire  [7:0] rx_data,
    output cmd_t       cmd
);

    logic [8:0] byte_cnt;   // Bytes received so far in this packet
    logic [7:0] len;        // Payload length N
    logic [7:0] opcode;
    logic       cmd_valid;
    logic       last_byte;

    // Byte N+3 closes the packet
    assign last_byte = rx_valid && (byte_cnt > 9'd2) && (byte_cnt == {1'b0, len} + 9'd2);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            byte_cnt  <= '0;
            len       <= '0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            cmd_valid <= last_byte;
            if (rx_valid)
            begin
                if (last_byte)
                    byte_cnt <= '0;
                else
                    byte_cnt <= byte_cnt + 9'd1;
                if (byte_cnt == 9'd1)
                    len <= rx_data;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_valid && byte_cnt == 9'd2)
            opcode <= rx_data;
    end

    assign cmd = {cmd_valid, opcode};

endmodule

`default_nettype wire

// File: rtl/command_engine.sv
`timescale 1ns/1ps
`default_nettype none

module command_engine import prog_pkg::*, flash_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire cmd_t  cmd,
    input  wire        spi_busy,
    input  wire  [7:0] spi_rdata,
    input  wire        reply_busy,
    output spi_req_t   spi_req,
    output logic       cs_n,
    output reply_t     reply
);

    typedef enum logic [4:0] {
        ST_IDLE,
        ST_DECODE,
        ST_SPI_ISSUE,
        ST_SPI_HOLD,
        ST_SPI_WAIT,
        ST_XFER_END,
        ST_ID_DONE,
        ST_SR1_DONE,
        ST_SR2_DONE,
        ST_WEL_POLL,
        ST_WEL_CHECK,
        ST_BSY_POLL,
        ST_BSY_CHECK,
        ST_REPLY,
        ST_REPLY_HOLD,
        ST_REPLY_WAIT
    } eng_state_t;

    eng_state_t      state;
    eng_state_t      after_xfer;  // Where to go once cs_n rises
    logic [7:0]      op;
    logic [1:0]      byte_left;   // Dummy bytes still to clock
    logic [2:0][7:0] rx_buf;      // Last three bytes read, [0] newest

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state      <= ST_IDLE;
            after_xfer <= ST_IDLE;
            op         <= '0;
            byte_left  <= '0;
            rx_buf     <= '0;
            cs_n       <= 1'b1;
            spi_req    <= '0;
            reply      <= '0;
        end
        else
        begin
            spi_req.start <= 1'b0;
            reply.start   <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (cmd.valid)
                    begin
                        op    <= cmd.opcode;
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE:
                begin
                    case (prog_op_t'(op))
                        OP_PING:
                        begin
                            reply.len  <= 2'd1;
                            reply.data <= '0;
                            state      <= ST_REPLY;
                        end
                        OP_READ_ID:
                        begin
                            spi_req.data <= FL_READ_ID;
                            byte_left    <= 2'd3;  // Three ID bytes follow
                            after_xfer   <= ST_ID_DONE;
                            state        <= ST_SPI_ISSUE;
                        end
                        OP_READ_SREG:
                        begin
                            spi_req.data <= FL_READ_SR1;
                            byte_left    <= 2'd1;
                            after_xfer   <= ST_SR1_DONE;
                            state        <= ST_SPI_ISSUE;
                        end
                        OP_ERASE:
                        begin
                            spi_req.data <= FL_WRITE_EN;
                            byte_left    <= 2'd0;
                            after_xfer   <= ST_WEL_POLL;
                            state        <= ST_SPI_ISSUE;
                        end
                        default:
                            state <= ST_IDLE;  // Unknown opcode gets no reply
                    endcase
                end

                ////////////////////////////////////////
                // One flash transaction, cs_n held low

                ST_SPI_ISSUE:
                begin
                    cs_n          <= 1'b0;
                    spi_req.start <= 1'b1;
                    state         <= ST_SPI_HOLD;
                end
                ST_SPI_HOLD:
                    state <= ST_SPI_WAIT;  // spi_busy rises here
                ST_SPI_WAIT:
                begin
                    if (!spi_busy)
                    begin
                        rx_buf <= {rx_buf[1:0], spi_rdata};
                        if (byte_left == 2'd0)
                            state <= ST_XFER_END;
                        else
                        begin
                            byte_left    <= byte_left - 2'd1;
                            spi_req.data <= FL_DUMMY;
                            state        <= ST_SPI_ISSUE;
                        end
                    end
                end
                ST_XFER_END:
                begin
                    cs_n  <= 1'b1;
                    state <= after_xfer;
                end

                ////////////////////////////////////////
                // Command steps

                ST_ID_DONE:
                begin
                    reply.len  <= 2'd3;
                    reply.data <= {rx_buf[2], rx_buf[0], rx_buf[1]};  // ID2, ID3, ID1
                    state      <= ST_REPLY;
                end
                ST_SR1_DONE:
                begin
                    reply.data[0] <= rx_buf[0];
                    spi_req.data  <= FL_READ_SR2;
                    byte_left     <= 2'd1;
                    after_xfer    <= ST_SR2_DONE;
                    state         <= ST_SPI_ISSUE;
                end
                ST_SR2_DONE:
                begin
                    reply.data[1] <= rx_buf[0];
                    reply.data[2] <= '0;
                    reply.len     <= 2'd2;
                    state         <= ST_REPLY;
                end
                ST_WEL_POLL:
                begin
                    spi_req.data <= FL_READ_SR1;
                    byte_left    <= 2'd1;
                    after_xfer   <= ST_WEL_CHECK;
                    state        <= ST_SPI_ISSUE;
                end
                ST_WEL_CHECK:
                begin
                    if (rx_buf[0][SR_WEL])
                    begin
                        spi_req.data <= FL_CHIP_ERASE;
                        byte_left    <= 2'd0;
                        after_xfer   <= ST_BSY_POLL;
                        state        <= ST_SPI_ISSUE;
                    end
                    else
                        state <= ST_WEL_POLL;
                end
                ST_BSY_POLL:
                begin
                    spi_req.data <= FL_READ_SR1;
                    byte_left    <= 2'd1;
                    after_xfer   <= ST_BSY_CHECK;
                    state        <= ST_SPI_ISSUE;
                end
                ST_BSY_CHECK:
                begin
                    if (rx_buf[0][SR_BSY])
                        state <= ST_BSY_POLL;  // Erase still running
                    else
                    begin
                        reply.len  <= 2'd1;
                        reply.data <= '0;
                        state      <= ST_REPLY;
                    end
                end

                ////////////////////////////////////////
                // Hand reply to the sender

                ST_REPLY:
                begin
                    reply.start  <= 1'b1;
                    reply.opcode <= op;
                    state        <= ST_REPLY_HOLD;
                end
                ST_REPLY_HOLD:
                    state <= ST_REPLY_WAIT;  // reply_busy rises here
                ST_REPLY_WAIT:
                begin
                    if (!reply_busy)
                        state <= ST_IDLE;
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/reply_sender.sv
`timescale 1ns/1ps
`default_nettype none

module reply_sender import prog_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire reply_t reply,
    input  wire         tx_busy,
    output logic        tx_start,
    output logic [7:0]  tx_data,
    output logic        reply_busy
);

    typedef enum logic [1:0] {RS_IDLE, RS_LOAD, RS_HOLD, RS_WAIT} rs_state_t;

    rs_state_t  state;
    reply_t     held;      // Reply being sent
    logic [2:0] idx;       // Byte position within the reply
    logic [7:0] cur_byte;

    always_comb
    begin
        case (idx)
            3'd0:    cur_byte = REPLY_HEAD;
            3'd1:    cur_byte = {6'd0, held.len};
            3'd2:    cur_byte = held.opcode;
            3'd3:    cur_byte = held.data[0];
            3'd4:    cur_byte = held.data[1];
            default: cur_byte = held.data[2];
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state    <= RS_IDLE;
            idx      <= '0;
            tx_start <= 1'b0;
        end
        else
        begin
            tx_start <= 1'b0;
            case (state)
                RS_IDLE:
                begin
                    if (reply.start)
                    begin
                        idx   <= '0;
                        state <= RS_LOAD;
                    end
                end
                RS_LOAD:
                begin
                    tx_start <= 1'b1;
                    state    <= RS_HOLD;
                end
                RS_HOLD:
                    state <= RS_WAIT;  // tx_busy rises here
                RS_WAIT:
                begin
                    if (!tx_busy)
                    begin
                        if (idx == {1'b0, held.len} + 3'd2)
                            state <= RS_IDLE;  // Header plus len bytes sent
                        else
                        begin
                            idx   <= idx + 3'd1;
                            state <= RS_LOAD;
                        end
                    end
                end
                default:
                    state <= RS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == RS_IDLE && reply.start)
            held <= reply;
        if (state == RS_LOAD)
            tx_data <= cur_byte;
    end

    assign reply_busy = (state != RS_IDLE);

endmodule

`default_nettype wire

// File: rtl/flash_programmer.sv
`timescale 1ns/1ps
`default_nettype none

module flash_programmer import prog_pkg::*, flash_pkg::*; #(
    parameter int CLKS_PER_BIT  = 8,
    parameter int SPI_HALF_CLKS = 2
)
(
    input  wire clk,
    input  wire rst,
    input  wire rx,
    output wire tx,
    input  wire miso,
    output wire mosi,
    output wire sck,
    output wire cs,
    output wire wp,
    output wire hold
);

    logic       rx_valid;
    logic [7:0] rx_data;
    cmd_t       cmd;
    spi_req_t   spi_req;
    logic       spi_busy;
    logic [7:0] spi_rdata;
    reply_t     reply;
    logic       reply_busy;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;

    // Board needs these pins inactive
    assign wp   = 1'b1;
    assign hold = 1'b1;

    ////////////////////////////////////////
    // Host side

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    packet_receiver u_packet_receiver (
        .clk      (clk),
        .rst      (rst),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .cmd      (cmd)
    );

    reply_sender u_reply_sender (
        .clk        (clk),
        .rst        (rst),
        .reply      (reply),
        .tx_busy    (tx_busy),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .reply_busy (reply_busy)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    ////////////////////////////////////////
    // Flash side

    command_engine u_command_engine (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .spi_busy   (spi_busy),
        .spi_rdata  (spi_rdata),
        .reply_busy (reply_busy),
        .spi_req    (spi_req),
        .cs_n       (cs),
        .reply      (reply)
    );

    spi_master #(.SPI_HALF_CLKS(SPI_HALF_CLKS)) u_spi_master (
        .clk   (clk),
        .rst   (rst),
        .req   (spi_req),
        .miso  (miso),
        .mosi  (mosi),
        .sck   (sck),
        .busy  (spi_busy),
        .rdata (spi_rdata)
    );

endmodule

`default_nettype wire

// File: test/spi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model import flash_pkg::*; #(
    parameter logic [23:0] JEDEC_ID = 24'hEF4018,
    parameter logic [7:0]  SR2_INIT = 8'h02,
    parameter int          ERASE_CS = 40
)
(
    input  wire  cs,
    input  wire  sck,
    input  wire  mosi,
    output logic miso
);

    logic [7:0] in_sr      = '0;
    logic [7:0] out_sr     = '0;
    logic [7:0] op         = '0;    // First byte of current transaction
    logic [2:0] bit_cnt    = '0;
    int         byte_cnt   = 0;
    int         busy_left  = 0;     // Chip-selects until erase ends
    logic       bsy        = 1'b0;
    logic       wel        = 1'b0;
    logic       erase_seen = 1'b0;

    initial
        miso = 1'b0;

    // Byte presented after the idx-th byte of a transaction
    function automatic logic [7:0] resp_byte(input logic [7:0] cmd, input int idx);
        logic [7:0] sr1;
        sr1         = '0;
        sr1[SR_WEL] = wel;
        sr1[SR_BSY] = bsy;
        case (cmd)
            FL_READ_ID:
            begin
                case (idx)
                    0:       return JEDEC_ID[23:16];
                    1:       return JEDEC_ID[15:8];
                    2:       return JEDEC_ID[7:0];
                    default: return 8'h00;
                endcase
            end
            FL_READ_SR1: return sr1;
            FL_READ_SR2: return SR2_INIT;
            default:     return 8'h00;
        endcase
    endfunction

    always @(negedge cs)
    begin
        bit_cnt  = '0;
        byte_cnt = 0;
        op       = '0;
        out_sr   = '0;
    end

    // Mode 0, sample on rising sck
    always @(posedge sck)
    begin
        logic [7:0] got;
        if (!cs)
        begin
            got     = {in_sr[6:0], mosi};
            in_sr   = got;
            bit_cnt = bit_cnt + 3'd1;
            if (bit_cnt == 3'd0)  // Eighth bit of a byte
            begin
                if (byte_cnt == 0)
                    op = got;
                out_sr   = resp_byte(op, byte_cnt);
                byte_cnt = byte_cnt + 1;
            end
        end
    end

    always @(negedge sck)
    begin
        if (!cs)
        begin
            miso   = out_sr[7];
            out_sr = {out_sr[6:0], 1'b0};
        end
    end

    // Commands take effect when cs rises
    always @(posedge cs)
    begin
        if (busy_left > 0)
        begin
            busy_left = busy_left - 1;
            if (busy_left == 0)
            begin
                bsy = 1'b0;
                wel = 1'b0;
            end
        end
        case (op)
            FL_WRITE_EN:
                wel = 1'b1;
            FL_CHIP_ERASE:
            begin
                if (wel && !bsy)
                begin
                    bsy        = 1'b1;
                    busy_left  = ERASE_CS;
                    erase_seen = 1'b1;
                end
            end
            default:
                ;
        endcase
    end

endmodule

`default_nettype wire

// File: test/flash_programmer_chk.sv
`timescale 1ns/1ps
`default_nettype none

module flash_programmer_chk
(
    input wire clk,
    input wire rst,
    input wire cs,
    input wire sck,
    input wire tx,
    input wire reply_busy
);

    int unsigned fail_cnt = 0;  // Count of failed assertions

    // Sampled away from the edges on which reset takes effect
    cs_in_reset: assert property (@(negedge clk) !rst |-> cs)
    else
    begin
        $error("cs low while reset is asserted");
        fail_cnt++;
    end

    sck_idle: assert property (@(posedge clk) disable iff (!rst) cs |-> !sck)
    else
    begin
        $error("sck high while cs is high");
        fail_cnt++;
    end

    tx_idle: assert property (@(posedge clk) disable iff (!rst) !reply_busy |-> tx)
    else
    begin
        $error("tx low while no reply is being sent");
        fail_cnt++;
    end

endmodule

bind flash_programmer flash_programmer_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .cs         (cs),
    .sck        (sck),
    .tx         (tx),
    .reply_busy (reply_busy)
);

`default_nettype wire

// File: test/tb_flash_programmer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_flash_programmer;

    localparam int         CLKS_PER_BIT  = 8;
    localparam int         SPI_HALF_CLKS = 2;
    localparam int         REPLY_WAIT    = 20000;  // Clocks until first reply start bit
    localparam int         SILENT_WAIT   = 2000;
    localparam logic [7:0] HEAD          = 8'hFE;
    localparam logic [7:0] ID1           = 8'hEF;
    localparam logic [7:0] ID2           = 8'h40;
    localparam logic [7:0] ID3           = 8'h18;
    localparam logic [7:0] SR2           = 8'h02;

    logic clk;
    logic rst;
    logic rx;
    wire  tx;
    wire  miso;
    wire  mosi;
    wire  sck;
    wire  cs;
    wire  wp;
    wire  hold;

    int seed;
    int errors;
    int failed_tests;
    int test_errors;  // Error count when the current test began

    flash_programmer #(
        .CLKS_PER_BIT  (CLKS_PER_BIT),
        .SPI_HALF_CLKS (SPI_HALF_CLKS)
    ) uut (
        .clk  (clk),
        .rst  (rst),
        .rx   (rx),
        .tx   (tx),
        .miso (miso),
        .mosi (mosi),
        .sck  (sck),
        .cs   (cs),
        .wp   (wp),
        .hold (hold)
    );

    spi_flash_model #(
        .JEDEC_ID ({ID1, ID2, ID3}),
        .SR2_INIT (SR2),
        .ERASE_CS (40)
    ) flash (
        .cs   (cs),
        .sck  (sck),
        .mosi (mosi),
        .miso (miso)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////
    // Host side UART

    function automatic logic [7:0] rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // Stop, data LSB first, start
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_packet(input logic [7:0] op, input int n);
        send_byte(rand_byte());  // Start byte, any value
        send_byte(8'(n));
        send_byte(op);
        for (int i = 0; i < n; i++)
            send_byte(rand_byte());
    endtask

    task automatic wait_start(input int limit, output logic seen);
        int t;
        seen = 1'b0;
        t    = 0;
        while (!seen && t < limit)
        begin
            @(posedge clk);
            seen = (tx == 1'b0);
            t++;
        end
    endtask

    task automatic recv_byte(input int limit, output logic [7:0] b, output logic ok);
        logic seen;
        b  = '0;
        ok = 1'b0;
        wait_start(limit, seen);
        if (seen)
        begin
            repeat (CLKS_PER_BIT / 2) @(posedge clk);  // Middle of start bit
            for (int i = 0; i < 8; i++)
            begin
                repeat (CLKS_PER_BIT) @(posedge clk);
                b[i] = tx;
            end
            repeat (CLKS_PER_BIT) @(posedge clk);
            check_byte("tx stop bit", {7'b0, tx}, 8'h01);
            ok = 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // Checks

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        assert (got === exp)
        else
        begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_reply(input logic [7:0] op, input int len, input logic [7:0] d0,
                                input logic [7:0] d1, input logic [7:0] d2);
        logic [7:0] exp [$];
        logic [7:0] b;
        logic       ok;
        exp.push_back(HEAD);
        exp.push_back(8'(len));
        exp.push_back(op);
        exp.push_back(d0);
        if (len > 1)
            exp.push_back(d1);
        if (len > 2)
            exp.push_back(d2);
        foreach (exp[i])
        begin
            recv_byte((i == 0) ? REPLY_WAIT : 4 * CLKS_PER_BIT, b, ok);
            if (!ok)
            begin
                $display("timeout waiting for reply byte %0d to opcode 0x%h", i, op);
                errors++;
                return;
            end
            check_byte($sformatf("reply byte %0d", i), b, exp[i]);
        end
    endtask

    task automatic open_test();
        test_errors = errors;
    endtask

    task automatic report_test(input int num, input string what);
        if (errors == test_errors)
            $display("test %0d %s: ok", num, what);
        else
        begin
            $display("test %0d %s: failed", num, what);
            failed_tests++;
        end
    endtask

    ////////////////////////////////////////
    // Tests

    initial
    begin
        logic [7:0] sr1_exp;
        logic       seen;
        clk          = 1'b0;
        rst          = 1'b0;
        rx           = 1'b1;
        seed         = 32'he90d10cc;
        errors       = 0;
        failed_tests = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        repeat (20) @(posedge clk);

        open_test();
        send_packet(8'hCC, 1);
        expect_reply(8'hCC, 1, 8'h00, 8'h00, 8'h00);
        check_byte("wp", {7'b0, wp}, 8'h01);
        check_byte("hold", {7'b0, hold}, 8'h01);
        report_test(1, "ping");

        open_test();
        send_packet(8'hF0, 1);
        expect_reply(8'hF0, 3, ID2, ID3, ID1);  // Reply slot order
        report_test(2, "read id");

        open_test();
        sr1_exp = {6'b0, flash.wel, flash.bsy};  // WEL bit 1, BSY bit 0
        send_packet(8'hF1, 1);
        expect_reply(8'hF1, 2, sr1_exp, SR2, 8'h00);
        report_test(3, "read status");

        open_test();
        send_packet(8'hF4, 1);
        expect_reply(8'hF4, 1, 8'h00, 8'h00, 8'h00);
        check_byte("flash erase_seen", {7'b0, flash.erase_seen}, 8'h01);
        check_byte("flash bsy", {7'b0, flash.bsy}, 8'h00);
        check_byte("flash wel", {7'b0, flash.wel}, 8'h00);
        report_test(4, "chip erase");

        open_test();
        send_packet(8'h5A, 3);
        wait_start(SILENT_WAIT, seen);
        assert (!seen)
        else
        begin
            $display("a reply started after an unknown opcode");
            errors++;
        end
        send_packet(8'hCC, 1);
        expect_reply(8'hCC, 1, 8'h00, 8'h00, 8'h00);
        report_test(5, "unknown opcode");

        $display("tests run 5, tests failed %0d, errors %0d, assertion failures %0d",
                 failed_tests, errors, uut.u_chk.fail_cnt);
        if (errors == 0 && uut.u_chk.fail_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rtl/prog_pkg.sv
rtl/flash_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/spi_master.sv
rtl/packet_receiver.sv
rtl/command_engine.sv
rtl/reply_sender.sv
rtl/flash_programmer.sv
test/spi_flash_model.sv
test/flash_programmer_chk.sv
test/tb_flash_programmer.sv
